// File: include/cpuCfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Datapath, address and instruction width
`define CPU_WORD_BITS 32

// General register file size
`define CPU_REG_COUNT 32

// First fetch after reset
`define CPU_RESET_VECTOR 32'hbfc00000

// A fetch from here stops the core
`define CPU_HALT_ADDR 32'h00000000

// JAL return address register ($ra)
`define CPU_LINK_REG 31

// Result register brought out at the top
`define CPU_V0_REG 2

// Cycles from request acceptance to readdata
`define CPU_BUS_READ_LATENCY 1

`endif

// File: hw/mipsIsaPkg.sv
`include "cpuCfg.svh"

package mipsIsaPkg;

    typedef logic [$clog2(`CPU_REG_COUNT)-1:0] regIdx_t;
    typedef logic [4:0] shamt_t;

    // R-type shares primary opcode zero
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0a,
        OP_SLTIU = 6'h0b,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_XORI  = 6'h0e,
        OP_LUI   = 6'h0f,
        OP_LB    = 6'h20,
        OP_LW    = 6'h23,
        OP_LBU   = 6'h24,
        OP_SB    = 6'h28,
        OP_SW    = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_t;

    typedef enum logic [3:0] {
        ALU_AND    = 4'd0,
        ALU_OR     = 4'd1,
        ALU_ADD    = 4'd2,
        ALU_SUB    = 4'd3,
        ALU_SLT    = 4'd4,
        ALU_SLTU   = 4'd5,
        ALU_XOR    = 4'd6,
        ALU_SLL    = 4'd7,
        ALU_SRL    = 4'd8,
        ALU_SRA    = 4'd9,
        ALU_LUI    = 4'd10,
        ALU_PASS_A = 4'd11
    } aluOp_t;

    typedef enum logic [2:0] {
        MEM_NONE,
        MEM_LOAD_WORD,
        MEM_LOAD_BYTE,
        MEM_LOAD_BYTE_U,
        MEM_STORE_WORD,
        MEM_STORE_BYTE
    } memKind_t;

    typedef enum logic [2:0] {
        FLOW_SEQ,
        FLOW_BEQ,
        FLOW_BNE,
        FLOW_JUMP,
        FLOW_JUMP_LINK,
        FLOW_JUMP_REG
    } flowKind_t;

endpackage

// File: hw/cpuBusPkg.sv
`include "cpuCfg.svh"

package cpuBusPkg;

    typedef logic [`CPU_WORD_BITS-1:0] word_t;

    // One enable per byte lane
    typedef logic [`CPU_WORD_BITS/8-1:0] byteEn_t;

    typedef logic [$clog2(`CPU_WORD_BITS/8)-1:0] byteOfs_t;

    // HALTED is only left by reset
    typedef enum logic [2:0] {
        FETCH      = 3'd0,
        DECODE     = 3'd1,
        EXEC       = 3'd2,
        MEM        = 3'd3,
        WRITE_BACK = 3'd4,
        HALTED     = 3'd7
    } cpuState_t;

endpackage

// File: hw/registerFile.sv
`timescale 1ns/10ps
`include "cpuCfg.svh"

module registerFile
    import mipsIsaPkg::*, cpuBusPkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  regIdx_t rdIdxA,
    input  regIdx_t rdIdxB,
    output word_t   rdDataA,
    output word_t   rdDataB,
    input  logic    wrEn,
    input  regIdx_t wrIdx,
    input  word_t   wrData,
    output word_t   registerV0
);

    word_t regs [`CPU_REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrIdx != '0) begin
            regs[wrIdx] <= wrData;
        end
    end

    assign rdDataA = regs[rdIdxA];
    assign rdDataB = regs[rdIdxB];

    assign registerV0 = regs[`CPU_V0_REG];

    // Reset clears $zero and writes to it are dropped
    zeroRegReads: assert property (
        @(posedge clk) disable iff (reset)
        (rdIdxA != '0 || rdDataA == '0) && (rdIdxB != '0 || rdDataB == '0)
    );

endmodule

// File: hw/instrDecoder.sv
`timescale 1ns/10ps
`include "cpuCfg.svh"

module instrDecoder
    import mipsIsaPkg::*, cpuBusPkg::*;
(
    input  word_t     instr,
    output aluOp_t    aluOp,
    output logic      useImm,
    output word_t     immValue,
    output shamt_t    shamt,
    output regIdx_t   destReg,
    output logic      regWrite,
    output memKind_t  memKind,
    output flowKind_t flowKind
);

    opcode_t opcode;
    funct_t  funct;
    word_t   signImm;
    word_t   zeroImm;

    assign opcode  = opcode_t'(instr[31:26]);
    assign funct   = funct_t'(instr[5:0]);
    assign signImm = {{(`CPU_WORD_BITS-16){instr[15]}}, instr[15:0]};
    assign zeroImm = {{(`CPU_WORD_BITS-16){1'b0}}, instr[15:0]};
    assign shamt   = instr[10:6];

    always_comb begin
        // Loads and stores use the defaults for their address add
        aluOp    = ALU_ADD;
        useImm   = 1'b1;
        immValue = signImm;
        destReg  = instr[20:16];
        regWrite = 1'b0;
        memKind  = MEM_NONE;
        flowKind = FLOW_SEQ;
        case (opcode)
            OP_RTYPE: begin
                useImm   = 1'b0;
                destReg  = instr[15:11];
                regWrite = 1'b1;
                case (funct)
                    FN_SLL:  aluOp = ALU_SLL;
                    FN_SRL:  aluOp = ALU_SRL;
                    FN_SRA:  aluOp = ALU_SRA;
                    FN_ADDU: aluOp = ALU_ADD;
                    FN_SUBU: aluOp = ALU_SUB;
                    FN_AND:  aluOp = ALU_AND;
                    FN_OR:   aluOp = ALU_OR;
                    FN_XOR:  aluOp = ALU_XOR;
                    FN_SLT:  aluOp = ALU_SLT;
                    FN_SLTU: aluOp = ALU_SLTU;
                    FN_JR: begin
                        aluOp    = ALU_PASS_A;
                        regWrite = 1'b0;
                        flowKind = FLOW_JUMP_REG;
                    end
                    default: regWrite = 1'b0;
                endcase
            end
            OP_J: flowKind = FLOW_JUMP;
            OP_JAL: begin
                flowKind = FLOW_JUMP_LINK;
                destReg  = regIdx_t'(`CPU_LINK_REG);
                regWrite = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                // Compare by subtraction and test the zero flag
                aluOp    = ALU_SUB;
                useImm   = 1'b0;
                flowKind = (opcode == OP_BEQ) ? FLOW_BEQ : FLOW_BNE;
            end
            OP_ADDIU: regWrite = 1'b1;
            OP_SLTI: begin
                aluOp    = ALU_SLT;
                regWrite = 1'b1;
            end
            OP_SLTIU: begin
                aluOp    = ALU_SLTU;
                regWrite = 1'b1;
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                immValue = zeroImm;
                regWrite = 1'b1;
                aluOp    = (opcode == OP_ANDI) ? ALU_AND :
                           (opcode == OP_ORI)  ? ALU_OR  : ALU_XOR;
            end
            OP_LUI: begin
                aluOp    = ALU_LUI;
                regWrite = 1'b1;
            end
            OP_LW: begin
                memKind  = MEM_LOAD_WORD;
                regWrite = 1'b1;
            end
            OP_LB: begin
                memKind  = MEM_LOAD_BYTE;
                regWrite = 1'b1;
            end
            OP_LBU: begin
                memKind  = MEM_LOAD_BYTE_U;
                regWrite = 1'b1;
            end
            OP_SW: memKind = MEM_STORE_WORD;
            OP_SB: memKind = MEM_STORE_BYTE;
            default: ;
        endcase
    end

endmodule

// File: hw/alu.sv
`timescale 1ns/10ps

module alu
    import mipsIsaPkg::*, cpuBusPkg::*;
(
    input  aluOp_t op,
    input  word_t  a,
    input  word_t  b,
    input  shamt_t shamt,
    output word_t  result,
    output logic   zero
);

    logic signedLess;
    logic unsignedLess;

    assign signedLess   = $signed(a) < $signed(b);
    assign unsignedLess = a < b;

    always_comb begin
        case (op)
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_SLT:    result = word_t'(signedLess);
            ALU_SLTU:   result = word_t'(unsignedLess);
            ALU_XOR:    result = a ^ b;
            // Fixed shifts act on the rt operand
            ALU_SLL:    result = b << shamt;
            ALU_SRL:    result = b >> shamt;
            ALU_SRA:    result = $signed(b) >>> shamt;
            ALU_LUI:    result = b << 16;
            ALU_PASS_A: result = a;
            default:    result = '0;
        endcase
    end

    // Branch equality test
    assign zero = (result == '0);

endmodule

// File: hw/cpuControl.sv
`timescale 1ns/10ps
`include "cpuCfg.svh"

module cpuControl
    import mipsIsaPkg::*, cpuBusPkg::*;
(
    input  logic      clk,
    input  logic      reset,
    output word_t     address,
    output logic      write,
    output logic      read,
    input  logic      waitrequest,
    output word_t     writedata,
    output byteEn_t   byteenable,
    input  word_t     readdata,
    output logic      active,
    output word_t     instr,
    input  aluOp_t    aluOp,
    input  logic      useImm,
    input  word_t     immValue,
    input  shamt_t    shamt,
    input  regIdx_t   destReg,
    input  logic      regWrite,
    input  memKind_t  memKind,
    input  flowKind_t flowKind,
    output regIdx_t   rdIdxA,
    output regIdx_t   rdIdxB,
    input  word_t     rdDataA,
    input  word_t     rdDataB,
    output logic      wrEn,
    output regIdx_t   wrIdx,
    output word_t     wrData,
    output word_t     aluA,
    output word_t     aluB,
    output aluOp_t    aluOpOut,
    output shamt_t    aluShamt,
    input  word_t     aluResult,
    input  logic      aluZero
);

    cpuState_t state;
    word_t     pc;
    word_t     pcPlus4;
    word_t     pendTarget;
    word_t     flowTarget;
    // 1 while the branch retires, 2 while its delay slot retires
    logic [1:0] slotStep;
    logic      flowTaken;
    logic      isLoad;
    logic      isStore;
    logic      isByte;
    byteOfs_t  byteOfs;
    logic [7:0] loadByte;

    assign pcPlus4 = pc + word_t'(4);
    assign isStore = (memKind == MEM_STORE_WORD) || (memKind == MEM_STORE_BYTE);
    assign isLoad  = (memKind != MEM_NONE) && !isStore;
    assign isByte  = (memKind == MEM_LOAD_BYTE) || (memKind == MEM_LOAD_BYTE_U) ||
                     (memKind == MEM_STORE_BYTE);
    assign byteOfs = aluResult[1:0];

    always_comb begin
        case (flowKind)
            FLOW_BEQ:                   flowTaken = aluZero;
            FLOW_BNE:                   flowTaken = !aluZero;
            FLOW_JUMP, FLOW_JUMP_LINK,
            FLOW_JUMP_REG:              flowTaken = 1'b1;
            default:                    flowTaken = 1'b0;
        endcase
        case (flowKind)
            FLOW_JUMP, FLOW_JUMP_LINK: flowTarget = {pcPlus4[31:28], instr[25:0], 2'b00};
            FLOW_JUMP_REG:             flowTarget = aluA;
            default:                   flowTarget = pcPlus4 + (immValue << 2);
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= FETCH;
            pc       <= `CPU_RESET_VECTOR;
            slotStep <= 2'd0;
        end else begin
            case (state)
                FETCH: begin
                    if (pc == `CPU_HALT_ADDR) begin
                        state <= HALTED;
                    end else if (!waitrequest) begin
                        state <= DECODE;
                    end
                end
                DECODE: state <= EXEC;
                EXEC:   state <= MEM;
                MEM: begin
                    if (!((isLoad || isStore) && waitrequest)) begin
                        state <= WRITE_BACK;
                    end
                    if (flowTaken) begin
                        slotStep <= 2'd1;
                    end
                end
                WRITE_BACK: begin
                    state <= FETCH;
                    pc    <= (slotStep == 2'd2) ? pendTarget : pcPlus4;
                    if (slotStep == 2'd1) begin
                        slotStep <= 2'd2;
                    end else begin
                        slotStep <= 2'd0;
                    end
                end
                default: state <= HALTED;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DECODE) begin
            instr <= readdata;
        end
        if (state == EXEC) begin
            aluA <= rdDataA;
            aluB <= useImm ? immValue : rdDataB;
        end
        if (state == MEM && flowTaken) begin
            pendTarget <= flowTarget;
        end
    end

    assign rdIdxA   = instr[25:21];
    assign rdIdxB   = instr[20:16];
    assign aluOpOut = aluOp;
    assign aluShamt = shamt;
    assign active   = (state != HALTED);

    // Bus master
    assign read  = ((state == FETCH) && (pc != `CPU_HALT_ADDR)) || ((state == MEM) && isLoad);
    assign write = (state == MEM) && isStore;
    assign address = (state == MEM) ? {aluResult[31:2], 2'b00} : {pc[31:2], 2'b00};
    assign writedata = (memKind == MEM_STORE_BYTE) ? {4{rdDataB[7:0]}} : rdDataB;
    assign byteenable = ((state == MEM) && isByte) ? byteEn_t'(4'b0001 << byteOfs) : '1;

    // Load data arrives during write-back
    assign loadByte = readdata[8*byteOfs +: 8];
    assign wrEn     = (state == WRITE_BACK) && regWrite;
    assign wrIdx    = destReg;

    always_comb begin
        case (memKind)
            MEM_LOAD_WORD:   wrData = readdata;
            MEM_LOAD_BYTE:   wrData = {{(`CPU_WORD_BITS-8){loadByte[7]}}, loadByte};
            MEM_LOAD_BYTE_U: wrData = {{(`CPU_WORD_BITS-8){1'b0}}, loadByte};
            default:         wrData = (flowKind == FLOW_JUMP_LINK) ? pc + word_t'(8) : aluResult;
        endcase
    end

    noReadWrite: assert property (
        @(posedge clk) disable iff (reset) !(read && write)
    );

    requestHeld: assert property (
        @(posedge clk) disable iff (reset)
        ((read || write) && waitrequest) |=>
            $stable(address) && $stable(read) && $stable(write) && $stable(byteenable) &&
            (!write || $stable(writedata))
    );

    haltIsFinal: assert property (
        @(posedge clk) disable iff (reset)
        (state == HALTED) |=> (state == HALTED) && !read && !write
    );

endmodule

// File: hw/mipsCpuBus.sv
`timescale 1ns/10ps

module mipsCpuBus
    import mipsIsaPkg::*, cpuBusPkg::*;
(
    input  logic    clk,
    input  logic    reset,
    output logic    active,
    output word_t   registerV0,
    output word_t   address,
    output logic    write,
    output logic    read,
    input  logic    waitrequest,
    output word_t   writedata,
    output byteEn_t byteenable,
    input  word_t   readdata
);

    word_t     instr;
    aluOp_t    aluOp;
    logic      useImm;
    word_t     immValue;
    shamt_t    shamt;
    regIdx_t   destReg;
    logic      regWrite;
    memKind_t  memKind;
    flowKind_t flowKind;
    regIdx_t   rdIdxA;
    regIdx_t   rdIdxB;
    word_t     rdDataA;
    word_t     rdDataB;
    logic      wrEn;
    regIdx_t   wrIdx;
    word_t     wrData;
    word_t     aluA;
    word_t     aluB;
    aluOp_t    aluOpSel;
    shamt_t    aluShamt;
    word_t     aluResult;
    logic      aluZero;

    cpuControl control_i (
        .clk(clk), .reset(reset),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata),
        .active(active), .instr(instr),
        .aluOp(aluOp), .useImm(useImm), .immValue(immValue), .shamt(shamt),
        .destReg(destReg), .regWrite(regWrite), .memKind(memKind), .flowKind(flowKind),
        .rdIdxA(rdIdxA), .rdIdxB(rdIdxB), .rdDataA(rdDataA), .rdDataB(rdDataB),
        .wrEn(wrEn), .wrIdx(wrIdx), .wrData(wrData),
        .aluA(aluA), .aluB(aluB), .aluOpOut(aluOpSel), .aluShamt(aluShamt),
        .aluResult(aluResult), .aluZero(aluZero)
    );

    instrDecoder decoder_i (
        .instr(instr), .aluOp(aluOp), .useImm(useImm), .immValue(immValue),
        .shamt(shamt), .destReg(destReg), .regWrite(regWrite),
        .memKind(memKind), .flowKind(flowKind)
    );

    alu alu_i (
        .op(aluOpSel), .a(aluA), .b(aluB), .shamt(aluShamt),
        .result(aluResult), .zero(aluZero)
    );

    registerFile regFile_i (
        .clk(clk), .reset(reset),
        .rdIdxA(rdIdxA), .rdIdxB(rdIdxB), .rdDataA(rdDataA), .rdDataB(rdDataB),
        .wrEn(wrEn), .wrIdx(wrIdx), .wrData(wrData), .registerV0(registerV0)
    );

endmodule

// File: tb/mipsCpuBus_tb.sv
`timescale 1ns/10ps
`include "cpuCfg.svh"

module mipsCpuBus_tb
    import mipsIsaPkg::*, cpuBusPkg::*;
();

    localparam int MAX_CYCLES = 4000;
    localparam int V0 = 2;
    localparam int T0 = 8;
    localparam int T1 = 9;
    localparam int T2 = 10;
    localparam int T3 = 11;
    localparam int T4 = 12;
    localparam int T5 = 13;
    localparam int T6 = 14;
    localparam int T7 = 15;
    localparam int RA = 31;

    logic    clk = 1'b0;
    logic    reset = 1'b1;
    logic    waitrequest = 1'b0;
    word_t   readdata = '0;
    logic    active;
    word_t   registerV0;
    word_t   address;
    logic    write;
    logic    read;
    word_t   writedata;
    byteEn_t byteenable;

    word_t progMem [64];
    word_t dataMem [64];
    int    progLen;
    int    storeCount;
    int    cycles = 0;
    int    waitRun = 0;
    logic  waitEnable = 1'b0;
    word_t fetched = '0;
    logic [31:0] rngState = 32'ha27b432f;

    mipsCpuBus dut_i (
        .clk(clk), .reset(reset), .active(active), .registerV0(registerV0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the CPU did not finish within %0d cycles", MAX_CYCLES);
            $display("tests failed");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic word_t fillWord(input word_t addr);
        return (addr * 32'h9e3779b1) ^ 32'h5ac30f1e;
    endfunction

    function automatic word_t laneMerge(input word_t old, input int ofs, input logic [7:0] b);
        word_t mask;
        mask = word_t'(32'hff) << (8 * ofs);
        return (old & ~mask) | (word_t'(b) << (8 * ofs));
    endfunction

    // Bus slave with program space at the reset vector and data space low
    always @(posedge clk) begin
        if (read && !waitrequest) begin
            fetched <= (address[31:28] == 4'hb) ? progMem[address[7:2]] : dataMem[address[7:2]];
        end
        if (write && !waitrequest) begin
            for (int i = 0; i < 4; i++) begin
                if (byteenable[i]) begin
                    dataMem[address[7:2]][8*i +: 8] = writedata[8*i +: 8];
                end
            end
            storeCount <= storeCount + 1;
        end
    end

    always @(negedge clk) begin
        readdata <= fetched;
        if (waitEnable) begin
            rngState = xorshift(rngState);
            if (rngState[0] && waitRun < 3) begin
                waitrequest <= 1'b1;
                waitRun <= waitRun + 1;
            end else begin
                waitrequest <= 1'b0;
                waitRun <= 0;
            end
        end else begin
            waitrequest <= 1'b0;
            waitRun <= 0;
        end
    end

    function automatic word_t rInstr(input int rs, input int rt, input int rd,
                                     input int sh, input logic [5:0] fn);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic word_t iInstr(input logic [5:0] op, input int rs, input int rt,
                                     input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    task automatic emit(input word_t w);
        progMem[progLen] = w;
        progLen++;
    endtask

    task automatic clearMemories();
        for (int i = 0; i < 64; i++) begin
            progMem[i] = '0;
            dataMem[i] = fillWord(word_t'(i * 4));
        end
        progLen = 0;
    endtask

    // Halt through JR $zero with a NOP in its slot
    task automatic emitHalt();
        emit(rInstr(0, 0, 0, 0, FN_JR));
        emit('0);
    endtask

    task automatic runProgram();
        @(negedge clk);
        reset = 1'b1;
        repeat (2) @(negedge clk);
        storeCount = 0;
        reset = 1'b0;
        @(negedge clk);
        while (active) @(negedge clk);
    endtask

    task automatic checkEq(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("tests failed");
            $fatal(1, "check failed");
        end
    endtask

    task automatic aluTest();
        word_t a;
        word_t b;
        word_t diff;
        word_t x;
        word_t expV0;
        clearMemories();
        emit(iInstr(OP_ADDIU, 0, T0, 16'hfffb));
        emit(iInstr(OP_LUI, 0, T1, 16'h1234));
        emit(iInstr(OP_ORI, T1, T1, 16'h8765));
        emit(rInstr(T1, T0, T2, 0, FN_SUBU));
        emit(rInstr(T2, T0, T3, 0, FN_XOR));
        emit(rInstr(T0, T1, T4, 0, FN_SLT));
        emit(rInstr(T0, T1, T5, 0, FN_SLTU));
        emit(rInstr(0, T0, T6, 2, FN_SRA));
        emit(rInstr(0, T3, T7, 3, FN_SLL));
        emit(rInstr(T7, T6, V0, 0, FN_ADDU));
        emit(rInstr(V0, T4, V0, 0, FN_ADDU));
        emit(rInstr(V0, T5, V0, 0, FN_ADDU));
        emitHalt();
        runProgram();
        a = 32'hfffffffb;
        b = 32'h12348765;
        diff = b - a;
        x = diff ^ a;
        expV0 = (x << 3) + word_t'($signed(a) >>> 2) + 32'd1 + 32'd0;
        checkEq("ALU chain v0", registerV0, expV0);
    endtask

    task automatic loadStoreTest();
        clearMemories();
        emit(iInstr(OP_ADDIU, 0, T1, 16'h0040));
        emit(iInstr(OP_LUI, 0, T0, 16'hcafe));
        emit(iInstr(OP_ORI, T0, T0, 16'hf00d));
        emit(iInstr(OP_SW, T1, T0, 16'h0000));
        emit(iInstr(OP_LW, T1, T2, 16'h0000));
        emit(iInstr(OP_SW, T1, T2, 16'h0004));
        emit(iInstr(OP_ADDIU, 0, T3, 16'h0011));
        emit(iInstr(OP_SB, T1, T3, 16'h0010));
        emit(iInstr(OP_ADDIU, 0, T3, 16'h0022));
        emit(iInstr(OP_SB, T1, T3, 16'h0015));
        emit(iInstr(OP_ADDIU, 0, T3, 16'h0033));
        emit(iInstr(OP_SB, T1, T3, 16'h001a));
        emit(iInstr(OP_ADDIU, 0, T3, 16'h0044));
        emit(iInstr(OP_SB, T1, T3, 16'h001f));
        emit(iInstr(OP_LB, T1, T4, 16'h0003));
        emit(iInstr(OP_SW, T1, T4, 16'h0020));
        emit(iInstr(OP_LBU, T1, V0, 16'h0003));
        emitHalt();
        runProgram();
        checkEq("SW word", dataMem[16], 32'hcafef00d);
        checkEq("LW copy", dataMem[17], 32'hcafef00d);
        checkEq("SB offset 0", dataMem[20], laneMerge(fillWord(32'h50), 0, 8'h11));
        checkEq("SB offset 1", dataMem[21], laneMerge(fillWord(32'h54), 1, 8'h22));
        checkEq("SB offset 2", dataMem[22], laneMerge(fillWord(32'h58), 2, 8'h33));
        checkEq("SB offset 3", dataMem[23], laneMerge(fillWord(32'h5c), 3, 8'h44));
        checkEq("LB sign extension", dataMem[24], 32'hffffffca);
        checkEq("LBU zero extension v0", registerV0, 32'h000000ca);
        checkEq("store count", word_t'(storeCount), 32'd7);
    endtask

    // Every branch offset is 2, each slot adds 1 and skipped words add 0x100
    task automatic loadBranchProgram();
        clearMemories();
        emit(iInstr(OP_ADDIU, 0, T0, 16'd5));
        emit(iInstr(OP_ADDIU, 0, T1, 16'd5));
        emit(iInstr(OP_BEQ, T0, T1, 16'd2));
        emit(iInstr(OP_ADDIU, V0, V0, 16'h0001));
        emit(iInstr(OP_ADDIU, V0, V0, 16'h0100));
        emit(iInstr(OP_BNE, T0, T1, 16'd2));
        emit(iInstr(OP_ADDIU, V0, V0, 16'h0001));
        emit(iInstr(OP_ADDIU, V0, V0, 16'h0010));
        emit(iInstr(OP_BEQ, T0, 0, 16'd2));
        emit(iInstr(OP_ADDIU, V0, V0, 16'h0001));
        emit(iInstr(OP_BNE, T0, 0, 16'd2));
        emit(iInstr(OP_ADDIU, V0, V0, 16'h0001));
        emit(iInstr(OP_ADDIU, V0, V0, 16'h0100));
        emit(iInstr(OP_SW, 0, V0, 16'h0080));
        emitHalt();
    endtask

    task automatic branchTest(input logic withWaits);
        loadBranchProgram();
        waitEnable = withWaits;
        runProgram();
        waitEnable = 1'b0;
        checkEq("branch v0", registerV0, 32'h00000014);
        checkEq("branch stored v0", dataMem[32], 32'h00000014);
        checkEq("branch store count", word_t'(storeCount), 32'd1);
    endtask

    task automatic jalTest();
        word_t subAddr;
        clearMemories();
        subAddr = `CPU_RESET_VECTOR + 32'd24;
        emit(iInstr(OP_ADDIU, 0, V0, 16'h0000));
        emit({OP_JAL, subAddr[27:2]});
        emit(iInstr(OP_ADDIU, V0, V0, 16'h0001));
        emit(iInstr(OP_ADDIU, V0, V0, 16'h0010));
        emitHalt();
        emit(iInstr(OP_SW, 0, RA, 16'h0084));
        emit(iInstr(OP_ADDIU, V0, V0, 16'h0100));
        emit(rInstr(RA, 0, 0, 0, FN_JR));
        emit(iInstr(OP_ADDIU, V0, V0, 16'h1000));
        runProgram();
        checkEq("JAL/JR v0", registerV0, 32'h00001111);
        checkEq("link value", dataMem[33], `CPU_RESET_VECTOR + 32'd4 + 32'd8);
    endtask

    task automatic haltTest();
        clearMemories();
        emit('0);
        emitHalt();
        runProgram();
        repeat (20) begin
            @(negedge clk);
            checkEq("read after halt", word_t'(read), 32'd0);
            checkEq("write after halt", word_t'(write), 32'd0);
            checkEq("active after halt", word_t'(active), 32'd0);
        end
    endtask

    initial begin
        aluTest();
        loadStoreTest();
        branchTest(1'b0);
        jalTest();
        branchTest(1'b1);
        haltTest();
        $display("all tests passed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
hw/mipsIsaPkg.sv
hw/cpuBusPkg.sv
hw/registerFile.sv
hw/instrDecoder.sv
hw/alu.sv
hw/cpuControl.sv
hw/mipsCpuBus.sv
tb/mipsCpuBus_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module mipsCpuBus_tb -o simv

# The simulator exits non-zero on $fatal, so keep going and let the search decide
out=$(./obj_dir/simv 2>&1) || true
echo "$out"

if grep -q "all tests passed" <<< "$out"; then
    exit 0
else
    exit 1
fi
